//--- dense_cfg_pkg.sv
package dense_cfg_pkg;

   // layer shape
   localparam int IN_LEN  = 8;
   localparam int OUT_LEN = 6;

   // two lanes, so each step of the row walk produces one even and one odd row
   localparam int PAIRS = OUT_LEN / 2;

   // word width for features, coefficients, accumulator and results
   localparam int WORD_W = 8;

   typedef logic signed [WORD_W-1:0] data_t;

   // column index into the feature buffer
   typedef logic [$clog2(IN_LEN)-1:0] col_t;

   // row-pair index
   typedef logic [1:0] pair_t;

endpackage

//--- dense_coef_pkg.sv
package dense_coef_pkg;

   import dense_cfg_pkg::*;

   localparam int W_DEPTH = PAIRS * IN_LEN;

   // lane 0 weights, even rows, one row pair per line
   localparam data_t W_LANE0 [W_DEPTH] = '{
      -8'sd10,  8'sd64,  -8'sd57,  -8'sd75, -8'sd18, -8'sd87, -8'sd38,  -8'sd81,
       8'sd98, -8'sd27,   8'sd13,  -8'sd26, -8'sd105, -8'sd69, 8'sd121, -8'sd4,
       8'sd82, -8'sd48,   8'sd73,  -8'sd64, -8'sd7,  -8'sd93, -8'sd17,   8'sd82
   };

   // lane 1 weights, odd rows
   localparam data_t W_LANE1 [W_DEPTH] = '{
      -8'sd40, -8'sd57,  -8'sd50,   8'sd27,  8'sd92, -8'sd25, -8'sd67,  8'sd106,
       8'sd18,  8'sd82,  -8'sd90,  -8'sd11, -8'sd99, -8'sd111, -8'sd119, 8'sd20,
      -8'sd22,  8'sd61,  -8'sd19,  -8'sd58, -8'sd92,  8'sd42, -8'sd80,  -8'sd122
   };

   // biases, indexed by row pair
   localparam data_t B_LANE0 [PAIRS] = '{
      -8'sd113,
      -8'sd20,
       8'sd121
   };

   localparam data_t B_LANE1 [PAIRS] = '{
       8'sd62,
      -8'sd89,
      -8'sd27
   };

endpackage

//--- layer_ctrl.sv
`timescale 1ns/1ps

module layer_ctrl
   import dense_cfg_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  data_t data_in,
   input  logic  s_valid,
   output logic  s_ready,
   output data_t x_word,
   output col_t  col,
   output pair_t pair,
   output logic  mac_first,
   output logic  mac_en,
   output logic  pair_load,
   input  logic  pair_full
);

   typedef enum logic [1:0] {
      ST_LOAD,
      ST_COMPUTE,
      ST_HANDOFF
   } state_t;

   state_t state;
   state_t next_state;

   data_t  feat_mem [IN_LEN];
   col_t   wr_col;
   col_t   rd_col;
   pair_t  pair_cnt;
   logic   word_in;
   logic   last_col;
   logic   last_pair;

   assign word_in   = s_valid && s_ready;
   assign last_col  = (rd_col == col_t'(IN_LEN - 1));
   assign last_pair = (pair_cnt == pair_t'(PAIRS - 1));

   // mac_en is still high on the first handoff cycle while the lanes take
   // column 7, so the results are ready one cycle later
   assign pair_load = (state == ST_HANDOFF) && !mac_en && !pair_full;

   always_comb begin
      next_state = state;
      case (state)
         ST_LOAD: begin
            if (word_in && wr_col == col_t'(IN_LEN - 1)) begin
               next_state = ST_COMPUTE;
            end
         end
         ST_COMPUTE: begin
            if (last_col) begin
               next_state = ST_HANDOFF;
            end
         end
         ST_HANDOFF: begin
            // wait here while the serializer still holds the previous pair
            if (pair_load) begin
               next_state = last_pair ? ST_LOAD : ST_COMPUTE;
            end
         end
         default: begin
            next_state = ST_LOAD;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ST_LOAD;
         s_ready <= 1'b0;
      end else begin
         state   <= next_state;
         s_ready <= (next_state == ST_LOAD);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_col   <= '0;
         rd_col   <= '0;
         pair_cnt <= '0;
      end else begin
         // both column counters wrap from 7 back to 0 on their own
         if (word_in) begin
            wr_col <= wr_col + 1'b1;
         end
         if (state == ST_COMPUTE) begin
            rd_col <= rd_col + 1'b1;
         end
         if (pair_load) begin
            pair_cnt <= last_pair ? '0 : pair_cnt + 1'b1;
         end
      end
   end

   // lane strobes line up with the registered buffer read
   always_ff @(posedge clk) begin
      if (reset) begin
         mac_en    <= 1'b0;
         mac_first <= 1'b0;
      end else begin
         mac_en    <= (state == ST_COMPUTE);
         mac_first <= (state == ST_COMPUTE) && (rd_col == '0);
      end
   end

   always_ff @(posedge clk) begin
      if (word_in) begin
         feat_mem[wr_col] <= data_in;
      end
      x_word <= feat_mem[rd_col];
      col    <= rd_col;
      pair   <= pair_cnt;
   end

endmodule

//--- neuron_lane.sv
`timescale 1ns/1ps

module neuron_lane
   import dense_cfg_pkg::*;
   import dense_coef_pkg::*;
#(
   parameter int LANE = 0
) (
   input  logic  clk,
   input  data_t x_word,
   input  col_t  col,
   input  pair_t pair,
   input  logic  mac_first,
   input  logic  mac_en,
   output data_t result
);

   logic [4:0]         w_idx;
   data_t              weight;
   data_t              bias;
   logic signed [15:0] prod_wide;
   data_t              prod;
   data_t              acc;
   data_t              acc_next;

   // pair * 8 + col
   assign w_idx = {pair, col};

   always_comb begin
      if (LANE == 0) begin
         weight = W_LANE0[w_idx];
         bias   = B_LANE0[pair];
      end else begin
         weight = W_LANE1[w_idx];
         bias   = B_LANE1[pair];
      end
   end

   // keep only the low byte of the product, read back as signed
   assign prod_wide = x_word * weight;
   assign prod      = data_t'(prod_wide[7:0]);

   // 8-bit accumulate, wraps in two's complement
   assign acc_next = (mac_first ? bias : acc) + prod;

   always_ff @(posedge clk) begin
      if (mac_en) begin
         acc    <= acc_next;
         // relu, zero unless strictly positive
         result <= (acc_next > 0) ? acc_next : '0;
      end
   end

endmodule

//--- output_serializer.sv
`timescale 1ns/1ps

module output_serializer
   import dense_cfg_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  data_t result_even,
   input  data_t result_odd,
   input  logic  pair_load,
   output logic  pair_full,
   output data_t data_out,
   output logic  m_valid,
   input  logic  m_ready
);

   data_t even_q;
   data_t odd_q;
   logic  odd_sel;
   logic  word_out;

   assign word_out = m_valid && m_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         m_valid <= 1'b0;
         odd_sel <= 1'b0;
      end else if (pair_load) begin
         m_valid <= 1'b1;
         odd_sel <= 1'b0;
      end else if (word_out) begin
         // second transfer empties the buffer
         if (odd_sel) begin
            m_valid <= 1'b0;
         end
         odd_sel <= !odd_sel;
      end
   end

   always_ff @(posedge clk) begin
      if (pair_load) begin
         even_q <= result_even;
         odd_q  <= result_odd;
      end
   end

   // even result first, then odd
   assign data_out = odd_sel ? odd_q : even_q;

   // busy until the odd word has left
   assign pair_full = m_valid;

endmodule

//--- dense_layer.sv
`timescale 1ns/1ps

module dense_layer
   import dense_cfg_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  data_t data_in,
   input  logic  s_valid,
   output logic  s_ready,
   output data_t data_out,
   output logic  m_valid,
   input  logic  m_ready
);

   data_t x_word;
   col_t  col;
   pair_t pair;
   logic  mac_first;
   logic  mac_en;
   logic  pair_load;
   logic  pair_full;
   data_t result_even;
   data_t result_odd;

   layer_ctrl u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .data_in   (data_in),
      .s_valid   (s_valid),
      .s_ready   (s_ready),
      .x_word    (x_word),
      .col       (col),
      .pair      (pair),
      .mac_first (mac_first),
      .mac_en    (mac_en),
      .pair_load (pair_load),
      .pair_full (pair_full)
   );

   // lane 0 takes the even rows, lane 1 the odd rows
   neuron_lane #(.LANE(0)) u_lane0 (
      .clk       (clk),
      .x_word    (x_word),
      .col       (col),
      .pair      (pair),
      .mac_first (mac_first),
      .mac_en    (mac_en),
      .result    (result_even)
   );

   neuron_lane #(.LANE(1)) u_lane1 (
      .clk       (clk),
      .x_word    (x_word),
      .col       (col),
      .pair      (pair),
      .mac_first (mac_first),
      .mac_en    (mac_en),
      .result    (result_odd)
   );

   output_serializer u_ser (
      .clk         (clk),
      .reset       (reset),
      .result_even (result_even),
      .result_odd  (result_odd),
      .pair_load   (pair_load),
      .pair_full   (pair_full),
      .data_out    (data_out),
      .m_valid     (m_valid),
      .m_ready     (m_ready)
   );

endmodule

//--- tb_dense_layer.sv
`timescale 1ns/1ps

module tb_dense_layer
   import dense_cfg_pkg::*;
();

   localparam int NUM_FRAMES = 8;
   localparam int VEC_W      = IN_LEN + OUT_LEN;
   localparam int NUM_PASSES = 4;
   localparam int WAIT_LIMIT = 500;

   logic  clk;
   logic  reset;
   data_t data_in;
   logic  s_valid;
   logic  s_ready;
   data_t data_out;
   logic  m_valid;
   logic  m_ready;

   logic [7:0] vectors [NUM_FRAMES * VEC_W];

   int   value_errors;
   int   proto_errors;
   int   words_checked;
   logic gaps_on;
   logic stall_on;

   dense_layer DUT (
      .clk      (clk),
      .reset    (reset),
      .data_in  (data_in),
      .s_valid  (s_valid),
      .s_ready  (s_ready),
      .data_out (data_out),
      .m_valid  (m_valid),
      .m_ready  (m_ready)
   );

   always #20 clk = ~clk;

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("errors: %0d value, %0d protocol, %0d words checked",
               value_errors, proto_errors, words_checked);
      $display("TESTS FAILED");
      $finish;
   endtask

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic send_word(input data_t w);
      int waited;
      int gap;
      waited = 0;
      gap = gaps_on ? int'($urandom % 3) : 0;
      s_valid = 1'b0;
      repeat (gap) @(negedge clk);
      s_valid = 1'b1;
      data_in = w;
      while (!s_ready) begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT) report_timeout("s_ready");
      end
      @(negedge clk);
   endtask

   task automatic send_frames();
      int f;
      int k;
      for (f = 0; f < NUM_FRAMES; f++) begin
         // frames sent apart in gap mode, back to back otherwise
         if (gaps_on) begin
            s_valid = 1'b0;
            repeat (int'($urandom % 24)) @(negedge clk);
         end
         for (k = 0; k < IN_LEN; k++) begin
            send_word(vectors[f * VEC_W + k]);
         end
      end
      s_valid = 1'b0;
   endtask

   task automatic check_word(input data_t expected, input int frame, input int row);
      words_checked++;
      if (data_out !== expected) begin
         $display("FAILED data_out frame %0d row %0d: expected %h, got %h",
                  frame, row, expected, data_out);
         value_errors++;
      end
      if (data_out[7] !== 1'b0) begin
         $display("FAILED data_out frame %0d row %0d: sign bit set, expected %h, got %h",
                  frame, row, expected, data_out);
         value_errors++;
      end
   endtask

   task automatic receive_word(input data_t expected, input int frame, input int row);
      int    waited;
      logic  done;
      logic  hold;
      data_t held;
      waited = 0;
      done = 1'b0;
      while (!done) begin
         m_ready = stall_on ? ($urandom % 3 != 0) : 1'b1;
         hold = m_valid && !m_ready;
         held = data_out;
         if (m_valid && m_ready) begin
            check_word(expected, frame, row);
            done = 1'b1;
         end
         @(negedge clk);
         // a stalled word must not move
         if (hold && (m_valid !== 1'b1 || data_out !== held)) begin
            $display("FAILED data_out during stall: expected %h, got %h, m_valid %h",
                     held, data_out, m_valid);
            proto_errors++;
         end
         waited++;
         if (!done && waited > WAIT_LIMIT) report_timeout("m_valid");
      end
   endtask

   task automatic receive_frames();
      int f;
      int r;
      for (f = 0; f < NUM_FRAMES; f++) begin
         for (r = 0; r < OUT_LEN; r++) begin
            receive_word(vectors[f * VEC_W + IN_LEN + r], f, r);
         end
      end
   endtask

   initial begin
      int pass;
      clk = 1'b0;
      reset = 1'b1;
      data_in = '0;
      s_valid = 1'b0;
      m_ready = 1'b0;
      value_errors = 0;
      proto_errors = 0;
      words_checked = 0;
      gaps_on = 1'b0;
      stall_on = 1'b0;
      void'($urandom(32'hacab));
      $readmemh("dense_layer_vectors.txt", vectors);
      if ($isunknown(vectors[NUM_FRAMES * VEC_W - 1])) begin
         $display("vector file is missing or shorter than expected");
         proto_errors++;
      end

      repeat (16) @(posedge clk);
      @(negedge clk);
      if (s_ready !== 1'b0 || m_valid !== 1'b0) begin
         $display("FAILED s_ready/m_valid in reset: expected 0/0, got %h/%h", s_ready, m_valid);
         proto_errors++;
      end
      reset = 1'b0;
      @(negedge clk);
      if (m_valid !== 1'b0) begin
         $display("FAILED m_valid after reset: expected 0, got %h", m_valid);
         proto_errors++;
      end
      if (s_ready !== 1'b1) begin
         $display("FAILED s_ready after reset: expected 1, got %h", s_ready);
         proto_errors++;
      end

      // pass 0 plain, 1 input gaps, 2 output stalls, 3 both
      for (pass = 0; pass < NUM_PASSES; pass++) begin
         gaps_on = pass[0];
         stall_on = pass[1];
         fork
            send_frames();
            receive_frames();
         join
      end

      m_ready = 1'b1;
      repeat (50) begin
         @(negedge clk);
         if (m_valid !== 1'b0) begin
            $display("extra word on the output after the last frame");
            proto_errors++;
         end
      end

      $display("errors: %0d value, %0d protocol, %0d words checked",
               value_errors, proto_errors, words_checked);
      if (value_errors == 0 && proto_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
dense_cfg_pkg.sv
dense_coef_pkg.sv
layer_ctrl.sv
neuron_lane.sv
output_serializer.sv
dense_layer.sv
tb_dense_layer.sv

//--- Makefile
TOP := tb_dense_layer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	@grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dense_layer_vectors.txt
// columns: in0..in7, then expected out0..out5 in stream order, 8-bit hex
// expected words are the wrapped 8-bit sums after relu
00 00 00 00 00 00 00 00  00 3e 00 00 79 00
01 00 00 00 00 00 00 00  00 16 4e 00 00 00
00 01 00 00 00 00 00 00  00 05 00 00 49 22
01 01 01 01 01 01 01 01  61 30 00 71 00 00
ff ff ff ff ff ff ff ff  00 4c 00 00 71 07
64 00 00 00 00 00 00 9c  4b 36 00 00 79 00
03 fe 05 07 fc 01 0a fa  22 58 04 29 00 00
00 00 00 00 80 7f 00 00  66 00 31 16 00 00
